//--- src/cpuTypesPkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// CPU shared types
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpuTypesPkg;

  localparam int WORD_W = 32;
  localparam int REG_W  = 5;

  typedef logic [WORD_W-1:0] word_t;   // Data word.
  typedef logic [REG_W-1:0]  regBits_t; // Register index.

  // Primary opcode field in instr[31:26].
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b
  } opcode_t;

  // R-type function field in instr[5:0].
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2a
  } funct_t;

  // ALU operation with the reset value at zero.
  typedef enum logic [3:0] {
    ALU_SLL = 4'h0,
    ALU_ADD = 4'h1,
    ALU_SUB = 4'h2,
    ALU_AND = 4'h3,
    ALU_OR  = 4'h4,
    ALU_XOR = 4'h5,
    ALU_SLT = 4'h6
  } aluop_t;

endpackage

`default_nettype wire

//--- src/pipeRegIf.sv
// ~~~~~~~~~~~~~~~~~~~~
// ID/EX record bundle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface pipeRegIf;
  import cpuTypesPkg::*;

  logic     regDst;   // Destination is rd.
  logic     branch;   // Conditional branch.
  logic     bne;      // Branch on not equal.
  logic     WEN;      // Register write.
  logic     aluSrc;   // Immediate operand.
  logic     jmp;      // J or JAL.
  logic     jl;       // Link address result.
  logic     jmpReg;   // JR.
  logic     memToReg; // Load result.
  logic     dREN;     // Data read.
  logic     dWEN;     // Data write.
  logic     lui;      // Upper immediate.
  logic     zeroExt;  // Zero-extend immediate.
  logic     shiftSel; // Shift by shamt.
  aluop_t   aluOp;
  word_t    instr;
  word_t    pc;
  word_t    incPC;
  word_t    rdat1;
  word_t    rdat2;
  word_t    imm;
  regBits_t dest;

  modport writer (
    output regDst, branch, bne, WEN, aluSrc, jmp, jl, jmpReg, memToReg,
    output dREN, dWEN, lui, zeroExt, shiftSel, aluOp,
    output instr, pc, incPC, rdat1, rdat2, imm, dest
  );

  modport reader (
    input regDst, branch, bne, WEN, aluSrc, jmp, jl, jmpReg, memToReg,
    input dREN, dWEN, lui, zeroExt, shiftSel, aluOp,
    input instr, pc, incPC, rdat1, rdat2, imm, dest
  );

endinterface

`default_nettype wire

//--- src/controlUnit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  cpuTypesPkg::word_t    instr,
  input  cpuTypesPkg::word_t    pc,
  pipeRegIf.writer              ctrl,
  output cpuTypesPkg::regBits_t rs,
  output cpuTypesPkg::regBits_t rt
);
  import cpuTypesPkg::*;

  opcode_t  opcode;
  funct_t   funct;
  regBits_t rd;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];

  assign ctrl.instr = instr;
  assign ctrl.pc    = pc;
  assign ctrl.incPC = pc + 32'd4;

  // Extended immediate.
  assign ctrl.imm = ctrl.zeroExt ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  // rd for R-type, ra for JAL, rt otherwise.
  assign ctrl.dest = ctrl.regDst ? rd : (ctrl.jl ? 5'd31 : rt);

  always_comb begin
    ctrl.regDst   = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.bne      = 1'b0;
    ctrl.WEN      = 1'b0;
    ctrl.aluSrc   = 1'b0;
    ctrl.jmp      = 1'b0;
    ctrl.jl       = 1'b0;
    ctrl.jmpReg   = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.dREN     = 1'b0;
    ctrl.dWEN     = 1'b0;
    ctrl.lui      = 1'b0;
    ctrl.zeroExt  = 1'b0;
    ctrl.shiftSel = 1'b0;
    ctrl.aluOp    = ALU_SLL;
    case (opcode)
      RTYPE: begin
        ctrl.regDst = 1'b1;
        ctrl.WEN    = (funct != JR);
        case (funct)
          SLL:     ctrl.shiftSel = 1'b1;
          JR:      ctrl.jmpReg   = 1'b1;
          ADDU:    ctrl.aluOp    = ALU_ADD;
          SUBU:    ctrl.aluOp    = ALU_SUB;
          AND:     ctrl.aluOp    = ALU_AND;
          OR:      ctrl.aluOp    = ALU_OR;
          XOR:     ctrl.aluOp    = ALU_XOR;
          SLT:     ctrl.aluOp    = ALU_SLT;
          default: ctrl.WEN      = 1'b0; // Unknown funct is a bubble.
        endcase
      end
      ADDIU: {ctrl.WEN, ctrl.aluSrc, ctrl.aluOp} = {2'b11, ALU_ADD};
      ORI:   {ctrl.WEN, ctrl.aluSrc, ctrl.zeroExt, ctrl.aluOp} = {3'b111, ALU_OR};
      LUI:   {ctrl.WEN, ctrl.lui, ctrl.zeroExt} = 3'b111;
      LW:    {ctrl.WEN, ctrl.dREN, ctrl.memToReg, ctrl.aluSrc, ctrl.aluOp} = {4'hf, ALU_ADD};
      SW:    {ctrl.dWEN, ctrl.aluSrc, ctrl.aluOp} = {2'b11, ALU_ADD};
      BEQ:   {ctrl.branch, ctrl.aluOp} = {1'b1, ALU_SUB};
      BNE:   {ctrl.branch, ctrl.bne, ctrl.aluOp} = {2'b11, ALU_SUB};
      J:     ctrl.jmp = 1'b1;
      JAL:   {ctrl.jmp, ctrl.jl, ctrl.WEN} = 3'b111; // Link into ra.
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/registerFile.sv
// ~~~~~~~~~~~~~~~~~~~~
// Register file
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  wbWEN,
  input  cpuTypesPkg::regBits_t wbReg,
  input  cpuTypesPkg::word_t    wbData,
  input  cpuTypesPkg::regBits_t rsel1,
  input  cpuTypesPkg::regBits_t rsel2,
  output cpuTypesPkg::word_t    rdat1,
  output cpuTypesPkg::word_t    rdat2
);
  import cpuTypesPkg::*;

  word_t regs [32];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWEN && (wbReg != '0)) begin
      regs[wbReg] <= wbData; // r0 is never written.
    end
  end

  // Write-first bypass on both read ports.
  assign rdat1 = (rsel1 == '0) ? '0 :
                 (wbWEN && (wbReg == rsel1)) ? wbData : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 :
                 (wbWEN && (wbReg == rsel2)) ? wbData : regs[rsel2];

  wbKnown: assert property (@(posedge CLK) disable iff (!nRST)
    wbWEN |-> !$isunknown({wbReg, wbData}))
    else $error("Writeback enabled with an unknown register or data.");

endmodule

`default_nettype wire

//--- src/pipeRegIdEx.sv
// ~~~~~~~~~~~~~~~~~~~~
// ID/EX pipeline register
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pipeRegIdEx (
  input logic      CLK,
  input logic      nRST,
  input logic      ihit,
  input logic      enable,
  input logic      flush,
  pipeRegIf.reader prIdExIn,
  pipeRegIf.writer prIdExOut
);
  import cpuTypesPkg::*;

  logic kill;

  assign kill = flush && ihit; // Flush only moves with the pipe.

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      prIdExOut.regDst   <= 1'b0;
      prIdExOut.branch   <= 1'b0;
      prIdExOut.bne      <= 1'b0;
      prIdExOut.WEN      <= 1'b0;
      prIdExOut.aluSrc   <= 1'b0;
      prIdExOut.jmp      <= 1'b0;
      prIdExOut.jl       <= 1'b0;
      prIdExOut.jmpReg   <= 1'b0;
      prIdExOut.memToReg <= 1'b0;
      prIdExOut.dREN     <= 1'b0;
      prIdExOut.dWEN     <= 1'b0;
      prIdExOut.lui      <= 1'b0;
      prIdExOut.zeroExt  <= 1'b0;
      prIdExOut.shiftSel <= 1'b0;
      prIdExOut.aluOp    <= ALU_SLL;
      prIdExOut.instr    <= '0;
      prIdExOut.pc       <= '0;
      prIdExOut.incPC    <= '0;
      prIdExOut.rdat1    <= '0;
      prIdExOut.rdat2    <= '0;
      prIdExOut.imm      <= '0;
      prIdExOut.dest     <= '0;
    end else if (kill || enable) begin
      // Flush loads a bubble, otherwise copy the record.
      prIdExOut.regDst   <= kill ? 1'b0 : prIdExIn.regDst;
      prIdExOut.branch   <= kill ? 1'b0 : prIdExIn.branch;
      prIdExOut.bne      <= kill ? 1'b0 : prIdExIn.bne;
      prIdExOut.WEN      <= kill ? 1'b0 : prIdExIn.WEN;
      prIdExOut.aluSrc   <= kill ? 1'b0 : prIdExIn.aluSrc;
      prIdExOut.jmp      <= kill ? 1'b0 : prIdExIn.jmp;
      prIdExOut.jl       <= kill ? 1'b0 : prIdExIn.jl;
      prIdExOut.jmpReg   <= kill ? 1'b0 : prIdExIn.jmpReg;
      prIdExOut.memToReg <= kill ? 1'b0 : prIdExIn.memToReg;
      prIdExOut.dREN     <= kill ? 1'b0 : prIdExIn.dREN;
      prIdExOut.dWEN     <= kill ? 1'b0 : prIdExIn.dWEN;
      prIdExOut.lui      <= kill ? 1'b0 : prIdExIn.lui;
      prIdExOut.zeroExt  <= kill ? 1'b0 : prIdExIn.zeroExt;
      prIdExOut.shiftSel <= kill ? 1'b0 : prIdExIn.shiftSel;
      prIdExOut.aluOp    <= kill ? ALU_SLL : prIdExIn.aluOp;
      prIdExOut.instr    <= kill ? '0 : prIdExIn.instr;
      prIdExOut.pc       <= kill ? '0 : prIdExIn.pc;
      prIdExOut.incPC    <= kill ? '0 : prIdExIn.incPC;
      prIdExOut.rdat1    <= kill ? '0 : prIdExIn.rdat1;
      prIdExOut.rdat2    <= kill ? '0 : prIdExIn.rdat2;
      prIdExOut.imm      <= kill ? '0 : prIdExIn.imm;
      prIdExOut.dest     <= kill ? '0 : prIdExIn.dest;
    end
  end

  holdWithoutIhit: assert property (@(posedge CLK) disable iff (!nRST)
    !ihit |=> $stable({prIdExOut.instr, prIdExOut.WEN, prIdExOut.dREN, prIdExOut.dWEN}))
    else $error("ID/EX record changed while ihit was low.");

endmodule

`default_nettype wire

//--- src/executeStage.sv
// ~~~~~~~~~~~~~~~~~~~~
// Execute stage
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  pipeRegIf.reader           idex,
  output cpuTypesPkg::word_t aluResult,
  output cpuTypesPkg::word_t storeData,
  output logic               redirect,
  output cpuTypesPkg::word_t redirectPc
);
  import cpuTypesPkg::*;

  word_t      opB;
  word_t      aluOut;
  logic [4:0] shamt;
  logic       equal;
  logic       taken;

  assign opB   = idex.aluSrc ? idex.imm : idex.rdat2;
  assign shamt = idex.shiftSel ? idex.instr[10:6] : idex.rdat1[4:0];

  always_comb begin
    case (idex.aluOp)
      ALU_SLL: aluOut = idex.rdat2 << shamt;
      ALU_ADD: aluOut = idex.rdat1 + opB;
      ALU_SUB: aluOut = idex.rdat1 - opB;
      ALU_AND: aluOut = idex.rdat1 & opB;
      ALU_OR:  aluOut = idex.rdat1 | opB;
      ALU_XOR: aluOut = idex.rdat1 ^ opB;
      ALU_SLT: aluOut = {31'b0, $signed(idex.rdat1) < $signed(opB)};
      default: aluOut = '0;
    endcase
  end

  // Link address and upper immediate bypass the ALU.
  assign aluResult = idex.jl  ? idex.incPC :
                     idex.lui ? {idex.imm[15:0], 16'h0} : aluOut;

  assign storeData = idex.rdat2;

  // Branch resolution.
  assign equal    = (idex.rdat1 == idex.rdat2);
  assign taken    = idex.branch && (idex.bne ? !equal : equal);
  assign redirect = taken || idex.jmp || idex.jmpReg;

  always_comb begin
    if (idex.jmpReg) begin
      redirectPc = idex.rdat1;
    end else if (idex.jmp) begin
      redirectPc = {idex.incPC[31:28], idex.instr[25:0], 2'b00}; // Region jump.
    end else begin
      redirectPc = idex.incPC + {idex.imm[29:0], 2'b00};
    end
  end

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Hazard unit
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input  logic                  ihit,
  input  cpuTypesPkg::regBits_t rs,
  input  cpuTypesPkg::regBits_t rt,
  input  logic                  exDREN,
  input  cpuTypesPkg::regBits_t exDest,
  input  logic                  redirect,
  output logic                  stall,
  output logic                  enable,
  output logic                  flush
);

  // Load in ID/EX feeding the decoding instruction.
  assign stall = exDREN && (exDest != '0) && ((exDest == rs) || (exDest == rt));

  assign enable = ihit;
  assign flush  = stall || redirect; // Bubble into ID/EX.

  // A load in ID/EX never redirects.
  always_comb begin
    if (exDREN) begin
      assert (!redirect) else $error("Load in execute also redirects.");
    end
  end

endmodule

`default_nettype wire

//--- src/decodeExecute.sv
// ~~~~~~~~~~~~~~~~~~~~
// Decode and execute slice
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module decodeExecute (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  ihit,
  input  cpuTypesPkg::word_t    instr,
  input  cpuTypesPkg::word_t    pc,
  input  logic                  wbWEN,
  input  cpuTypesPkg::regBits_t wbReg,
  input  cpuTypesPkg::word_t    wbData,
  output logic                  stall,
  output cpuTypesPkg::word_t    aluResult,
  output cpuTypesPkg::word_t    storeData,
  output cpuTypesPkg::regBits_t exDest,
  output logic                  exWEN,
  output logic                  exDREN,
  output logic                  exDWEN,
  output logic                  redirect,
  output cpuTypesPkg::word_t    redirectPc
);
  import cpuTypesPkg::*;

  regBits_t rs;
  regBits_t rt;
  word_t    rfRdat1;
  word_t    rfRdat2;
  logic     idExEnable;
  logic     idExFlush;

  pipeRegIf idexIn ();
  pipeRegIf idexOut ();

  controlUnit decoder (
    .instr (instr),
    .pc    (pc),
    .ctrl  (idexIn.writer),
    .rs    (rs),
    .rt    (rt)
  );

  registerFile regFile (
    .CLK    (CLK),
    .nRST   (nRST),
    .wbWEN  (wbWEN),
    .wbReg  (wbReg),
    .wbData (wbData),
    .rsel1  (rs),
    .rsel2  (rt),
    .rdat1  (rfRdat1),
    .rdat2  (rfRdat2)
  );

  assign idexIn.rdat1 = rfRdat1;
  assign idexIn.rdat2 = rfRdat2;

  pipeRegIdEx idExReg (
    .CLK       (CLK),
    .nRST      (nRST),
    .ihit      (ihit),
    .enable    (idExEnable),
    .flush     (idExFlush),
    .prIdExIn  (idexIn.reader),
    .prIdExOut (idexOut.writer)
  );

  executeStage exStage (
    .idex       (idexOut.reader),
    .aluResult  (aluResult),
    .storeData  (storeData),
    .redirect   (redirect),
    .redirectPc (redirectPc)
  );

  hazardUnit hazards (
    .ihit     (ihit),
    .rs       (rs),
    .rt       (rt),
    .exDREN   (idexOut.dREN),
    .exDest   (idexOut.dest),
    .redirect (redirect),
    .stall    (stall),
    .enable   (idExEnable),
    .flush    (idExFlush)
  );

  // Execute-side control seen by later stages.
  assign exDest = idexOut.dest;
  assign exWEN  = idexOut.WEN;
  assign exDREN = idexOut.dREN;
  assign exDWEN = idexOut.dWEN;

endmodule

`default_nettype wire

//--- dv/decodeExecuteTb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Decode/execute testbench
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteTb;
  logic CLK, nRST, ihit, wbWEN, stall, exWEN, exDREN, exDWEN, redirect;
  logic [31:0] instr, pc, wbData, aluResult, storeData, redirectPc;
  logic [4:0] wbReg, exDest;
  logic [31:0] model [32]; // Expected register contents.
  integer seed = 89;
  int cycles = 0;

  decodeExecute uut (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .instr(instr), .pc(pc),
    .wbWEN(wbWEN), .wbReg(wbReg), .wbData(wbData), .stall(stall),
    .aluResult(aluResult), .storeData(storeData), .exDest(exDest),
    .exWEN(exWEN), .exDREN(exDREN), .exDWEN(exDWEN),
    .redirect(redirect), .redirectPc(redirectPc)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= 400) begin
      $display("Timeout: the tests did not finish within 400 clock cycles.");
      $display("STATUS: FAIL");
      $fatal(1, "Simulation timed out.");
    end
  end

  function automatic logic [31:0] encR(input logic [5:0] f, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [4:0] rd,
                                       input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, f};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("Fail at %0t: %s (got %h, expected %h)", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Check failed.");
    end
  endtask

  // One edge; the model follows any writeback driven this cycle.
  task automatic clockCycle(input logic hit);
    ihit = hit;
    @(posedge CLK);
    if (wbWEN && wbReg != 5'd0) model[wbReg] = wbData;
    #1;
    wbWEN = 1'b0;
  endtask

  task automatic present(input logic [31:0] w, input logic [31:0] p);
    instr = w;
    pc    = p;
  endtask

  task automatic issue(input logic [31:0] w, input logic [31:0] p);
    present(w, p);
    clockCycle(1'b1);
  endtask

  task automatic writeReg(input logic [4:0] r, input logic [31:0] v);
    wbWEN  = 1'b1;
    wbReg  = r;
    wbData = v;
    clockCycle(1'b0);
  endtask

  // Next slot after a taken redirect must be a bubble.
  task automatic flushedCheck();
    issue(encR(6'h21, 5'd1, 5'd2, 5'd9, 5'd0), 32'h0000_0800);
    checkEq(32'(exWEN), 32'd0, "flushed slot exWEN");
    checkEq(32'(redirect), 32'd0, "flushed slot redirect");
  endtask

  task automatic branchCheck(input logic isBne, input logic [4:0] rs, input logic [4:0] rt,
                             input logic [15:0] off, input logic [31:0] p);
    logic taken;
    taken = isBne ? (model[rs] != model[rt]) : (model[rs] == model[rt]);
    issue(encI(isBne ? 6'h05 : 6'h04, rs, rt, off), p);
    checkEq(32'(redirect), 32'(taken), "branch redirect");
    if (taken) begin
      checkEq(redirectPc, p + 32'd4 + {{14{off[15]}}, off, 2'b00}, "branch target");
      flushedCheck();
    end
  endtask

  task automatic resetValues();
    checkEq(32'(exWEN), 32'd0, "reset exWEN");
    checkEq(32'(exDREN), 32'd0, "reset exDREN");
    checkEq(32'(exDWEN), 32'd0, "reset exDWEN");
    checkEq(32'(redirect), 32'd0, "reset redirect");
    checkEq(32'(stall), 32'd0, "reset stall");
    checkEq(aluResult, 32'd0, "reset aluResult");
  endtask

  task automatic rtypeArith();
    logic [31:0] a, b, exp;
    logic [5:0] f;
    logic [4:0] sh;
    for (int r = 1; r < 16; r++) writeReg(5'(r), $random(seed));
    for (int k = 0; k < 7; k++) begin
      a  = model[k + 1];
      b  = model[k + 2];
      sh = 5'(k + 3);
      case (k)
        0: begin f = 6'h21; exp = a + b; end
        1: begin f = 6'h23; exp = a - b; end
        2: begin f = 6'h24; exp = a & b; end
        3: begin f = 6'h25; exp = a | b; end
        4: begin f = 6'h26; exp = a ^ b; end
        5: begin f = 6'h2a; exp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; end
        default: begin f = 6'h00; exp = b << sh; end
      endcase
      issue(encR(f, 5'(k + 1), 5'(k + 2), 5'(k + 16), sh), 32'h100 + 32'(k * 4));
      checkEq(aluResult, exp, "R-type aluResult");
      checkEq(32'(exDest), 32'(k + 16), "R-type exDest");
      checkEq(32'(exWEN), 32'd1, "R-type exWEN");
    end
    // Writeback to r2 in the same cycle as the read.
    wbWEN  = 1'b1;
    wbReg  = 5'd2;
    wbData = 32'h1357_9bdf;
    issue(encR(6'h21, 5'd1, 5'd2, 5'd17, 5'd0), 32'h120);
    checkEq(aluResult, model[1] + 32'h1357_9bdf, "bypassed ADDU");
  endtask

  task automatic immediatesAndMemory();
    issue(encI(6'h09, 5'd1, 5'd20, 16'hfff0), 32'h200);
    checkEq(aluResult, model[1] + 32'hffff_fff0, "ADDIU sign extend");
    issue(encI(6'h0d, 5'd2, 5'd21, 16'h8001), 32'h204);
    checkEq(aluResult, model[2] | 32'h0000_8001, "ORI zero extend");
    issue(encI(6'h0f, 5'd0, 5'd22, 16'h1234), 32'h208);
    checkEq(aluResult, 32'h1234_0000, "LUI result");
    checkEq(32'(exDest), 32'd22, "LUI exDest");
    issue(encI(6'h23, 5'd3, 5'd23, 16'h0008), 32'h20c);
    checkEq(aluResult, model[3] + 32'd8, "LW address");
    checkEq(32'(exDREN), 32'd1, "LW exDREN");
    checkEq(32'(exDest), 32'd23, "LW exDest");
    issue(encI(6'h2b, 5'd5, 5'd4, 16'hfffc), 32'h210);
    checkEq(aluResult, model[5] - 32'd4, "SW address");
    checkEq(32'(exDWEN), 32'd1, "SW exDWEN");
    checkEq(32'(exWEN), 32'd0, "SW exWEN");
    checkEq(storeData, model[4], "SW storeData");
  endtask

  task automatic redirectFlow();
    writeReg(5'd7, model[6]);
    writeReg(5'd10, 32'h0000_4a0c);
    branchCheck(1'b0, 5'd6, 5'd7, 16'h0005, 32'h300);  // Taken BEQ.
    branchCheck(1'b1, 5'd6, 5'd7, 16'h0005, 32'h310);  // BNE not taken.
    branchCheck(1'b0, 5'd1, 5'd2, 16'h0010, 32'h320);
    branchCheck(1'b1, 5'd6, 5'd1, 16'hfff8, 32'h330);  // Backward.
    issue({6'h02, 26'h0123456}, 32'h2000_0400);
    checkEq(32'(redirect), 32'd1, "J redirect");
    checkEq(redirectPc, {4'h2, 26'h0123456, 2'b00}, "J target");
    flushedCheck();
    issue({6'h03, 26'h0abcdef}, 32'h3000_0500);
    checkEq(32'(redirect), 32'd1, "JAL redirect");
    checkEq(redirectPc, {4'h3, 26'h0abcdef, 2'b00}, "JAL target");
    checkEq(aluResult, 32'h3000_0504, "JAL link");
    checkEq(32'(exDest), 32'd31, "JAL exDest");
    checkEq(32'(exWEN), 32'd1, "JAL exWEN");
    flushedCheck();
    issue(encR(6'h08, 5'd10, 5'd0, 5'd0, 5'd0), 32'h600);
    checkEq(32'(redirect), 32'd1, "JR redirect");
    checkEq(redirectPc, model[10], "JR target");
    flushedCheck();
  endtask

  task automatic loadUseStall();
    issue(encI(6'h23, 5'd1, 5'd11, 16'h0000), 32'h700);
    present(encR(6'h21, 5'd11, 5'd2, 5'd12, 5'd0), 32'h704);
    #1;
    checkEq(32'(stall), 32'd1, "load-use stall");
    clockCycle(1'b1);
    checkEq({exWEN, exDREN, exDWEN}, 32'd0, "load-use bubble");
    issue(encI(6'h23, 5'd1, 5'd0, 16'h0000), 32'h708);
    present(encR(6'h21, 5'd0, 5'd2, 5'd12, 5'd0), 32'h70c);
    #1;
    checkEq(32'(stall), 32'd0, "no stall on r0");
    clockCycle(1'b1);
    checkEq(aluResult, model[2], "ADDU after LW r0");
    checkEq(32'(exWEN), 32'd1, "ADDU after LW r0 exWEN");
  endtask

  task automatic backPressureHold();
    logic [31:0] exp;
    exp = model[1] + model[2];
    issue(encR(6'h21, 5'd1, 5'd2, 5'd13, 5'd0), 32'h800);
    present(encR(6'h26, 5'd3, 5'd4, 5'd14, 5'd0), 32'h804);
    repeat (3) begin
      clockCycle(1'b0);
      checkEq(aluResult, exp, "held aluResult");
      checkEq(32'(exDest), 32'd13, "held exDest");
    end
    issue({6'h02, 26'h0000040}, 32'h808);
    present(encR(6'h21, 5'd1, 5'd2, 5'd15, 5'd0), 32'h80c);
    repeat (3) begin
      clockCycle(1'b0);
      checkEq(32'(redirect), 32'd1, "held redirect");
      checkEq(redirectPc, 32'h0000_0100, "held target");
    end
    clockCycle(1'b1); // Flush lands with ihit.
    checkEq(32'(exWEN), 32'd0, "late flush exWEN");
    checkEq(32'(redirect), 32'd0, "late flush redirect");
  endtask

  initial begin
    nRST   = 1'b0;
    ihit   = 1'b0;
    instr  = 32'd0;
    pc     = 32'd0;
    wbWEN  = 1'b0;
    wbReg  = 5'd0;
    wbData = 32'd0;
    for (int r = 0; r < 32; r++) model[r] = 32'd0;
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    resetValues();
    rtypeArith();
    immediatesAndMemory();
    redirectFlow();
    loadUseStall();
    backPressureHold();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
src/cpuTypesPkg.sv
src/pipeRegIf.sv
src/controlUnit.sv
src/registerFile.sv
src/pipeRegIdEx.sv
src/executeStage.sv
src/hazardUnit.sv
src/decodeExecute.sv
dv/decodeExecuteTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= decodeExecuteTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)
